// ==== cache_pkg.sv ====
/* shared sizes and address field widths of the split L1 cache subsystem,
   the AXI response code and the bus arbiter state type. */

package cache_pkg;

  // processor ports and caches. port 0 fetches instructions and port 1 serves data.
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = $clog2(NUM_PORTS); // width of a port number.

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8; // one strobe bit per byte lane.

  // cache geometry.
  localparam int LINE_WORDS = 4;  // 32-bit words per line.
  localparam int NUM_LINES  = 16; // lines per cache.

  // address split from the top: tag, index, word offset and the ignored byte bits.
  localparam int BYTE_OFF_W = 2;
  localparam int OFFSET_W   = $clog2(LINE_WORDS);
  localparam int INDEX_W    = $clog2(NUM_LINES);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

  // AXI response codes are two bits wide and only OKAY counts as success.
  localparam int                RESP_W    = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  // the arbiter runs one AXI4-Lite transaction at a time through these states.
  typedef enum logic [2:0] {
    ARB_IDLE,  // waiting for a cache request.
    ARB_RADDR, // read address offered on AR.
    ARB_RDATA, // waiting for the R beat.
    ARB_WADDR, // address and data offered on AW and W together.
    ARB_WRESP  // waiting for the B response.
  } arb_state_t;

endpackage

// ==== mem_req_if.sv ====
/* request channel between one L1 cache and the bus arbiter,
   with a cache modport and an arbiter modport. */

`timescale 1ns/10ps

interface mem_req_if
  import cache_pkg::*;
(
  input logic CLK
);

  logic              req;     // a request is pending and held until done.
  logic              we;      // the pending request is a write.
  logic [ADDR_W-1:0] addr;    // word aligned address.
  logic [DATA_W-1:0] wdata;   // write data.
  logic              flushed; // the cache is idle with no valid lines.

  logic [DATA_W-1:0] rdata;   // returned word, valid with done.
  logic              done;    // one cycle pulse that ends the request.
  logic              error;   // the bus answered with an error response.

  // the cache owns the request fields.
  modport cache (
    input  CLK,
    output req, we, addr, wdata, flushed,
    input  rdata, done, error
  );

  // the arbiter answers them.
  modport arbiter (
    input  CLK,
    input  req, we, addr, wdata, flushed,
    output rdata, done, error
  );

endinterface

// ==== l1_cache.sv ====
/* one direct-mapped write-through L1 cache with critical word first refill,
   no-allocate writes and a fence driven flush of all valid bits. */

`timescale 1ns/10ps

module l1_cache
  import cache_pkg::*;
(
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              ren,
  input  logic              wen,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              busy,
  output logic              error,
  input  logic              fence,
  mem_req_if.cache          mem
);

  typedef enum logic [2:0] {
    ST_IDLE,   // waiting for a command or a fence.
    ST_LOOKUP, // tag compare on the registered address.
    ST_REFILL, // fetching the line one word at a time.
    ST_WTHRU,  // write going out to memory.
    ST_FLUSH,  // all lines invalid, held while fence stays high.
    ST_DONE    // result presented to the processor port.
  } cache_state_t;

  cache_state_t state;

  // storage arrays. only the valid bits are cleared on reset.
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [DATA_W-1:0]    data_mem [NUM_LINES][LINE_WORDS];
  logic [NUM_LINES-1:0] valid;

  logic [ADDR_W-1:0]   addr_q;   // address of the command being served.
  logic [DATA_W-1:0]   wdata_q;  // write data of that command.
  logic                we_q;     // the command is a write.
  logic [DATA_W-1:0]   rdata_q;  // word returned to the processor.
  logic                err_q;    // the bus reported an error for this command.
  logic [OFFSET_W-1:0] fill_cnt; // words of the refill already received.

  logic [OFFSET_W-1:0] off_q;
  logic [INDEX_W-1:0]  idx_q;
  logic [TAG_W-1:0]    tag_q;
  logic [OFFSET_W-1:0] fill_off;
  logic [OFFSET_W-1:0] bus_off;
  logic                hit;

  assign off_q = addr_q[BYTE_OFF_W +: OFFSET_W];
  assign idx_q = addr_q[BYTE_OFF_W + OFFSET_W +: INDEX_W];
  assign tag_q = addr_q[ADDR_W-1 -: TAG_W];

  // the refill starts at the requested word and wraps around the line.
  assign fill_off = off_q + fill_cnt; // the two bit sum wraps by itself.
  assign hit      = valid[idx_q] && (tag_mem[idx_q] == tag_q);

  // memory side. the fields only change on done, so they stay steady while req is up.
  assign bus_off     = (state == ST_REFILL) ? fill_off : off_q;
  assign mem.req     = (state == ST_REFILL) || (state == ST_WTHRU);
  assign mem.we      = (state == ST_WTHRU);
  assign mem.addr    = {tag_q, idx_q, bus_off, {BYTE_OFF_W{1'b0}}};
  assign mem.wdata   = wdata_q;
  assign mem.flushed = (state == ST_FLUSH); // every valid bit was cleared on entry.

  // processor side. busy drops for the single cycle in which the result is shown.
  assign busy  = (ren || wen) && (state != ST_DONE);
  assign error = (state == ST_DONE) && err_q;
  assign rdata = rdata_q;

  // controller and valid bits.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      valid    <= '0;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      fill_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (fence) begin // the fence wins over a new command.
            valid <= '0;
            state <= ST_FLUSH;
          end else if (ren || wen) begin
            we_q  <= wen;
            err_q <= 1'b0;
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (we_q) begin
            state <= ST_WTHRU; // every write goes through, hit or miss.
          end else if (hit) begin
            state <= ST_DONE;
          end else begin
            valid[idx_q] <= 1'b0; // the old line is lost as soon as words overwrite it.
            fill_cnt     <= '0;
            state        <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (mem.done) begin
            if (mem.error) begin
              err_q <= 1'b1; // the line stays invalid.
              state <= ST_DONE;
            end else if (fill_cnt == OFFSET_W'(LINE_WORDS - 1)) begin
              valid[idx_q] <= 1'b1; // all words arrived cleanly.
              state        <= ST_DONE;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
            end
          end
        end
        ST_WTHRU: begin
          if (mem.done) begin
            err_q <= mem.error;
            state <= ST_DONE;
          end
        end
        ST_FLUSH: if (!fence) state <= ST_IDLE;
        ST_DONE:  state <= ST_IDLE; // the processor takes the result in this cycle.
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // datapath: registered command, tag and data arrays, returned word.
  always_ff @(posedge CLK) begin
    if ((state == ST_IDLE) && !fence && (ren || wen)) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (state == ST_LOOKUP) begin
      if (hit && !we_q) rdata_q <= data_mem[idx_q][off_q];
      if (hit && we_q) data_mem[idx_q][off_q] <= wdata_q; // keep the cached copy current.
      if (!hit && !we_q) tag_mem[idx_q] <= tag_q; // guarded by the cleared valid bit.
    end
    if ((state == ST_REFILL) && mem.done && !mem.error) begin
      data_mem[idx_q][fill_off] <= mem.rdata;
      if (fill_off == off_q) rdata_q <= mem.rdata; // the critical word.
    end
  end

endmodule

// ==== bus_arbiter.sv ====
/* round-robin arbiter over the cache request channels with an AXI4-Lite master
   that runs one transaction at a time, plus the fence completion logic. */

`timescale 1ns/10ps

module bus_arbiter
  import cache_pkg::*;
(
  input  logic              CLK,
  input  logic              rst_n,
  mem_req_if.arbiter        cache [NUM_PORTS],
  input  logic              fence,
  output logic              fence_done,
  output logic [ADDR_W-1:0] awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [DATA_W-1:0] wdata,
  output logic [STRB_W-1:0] wstrb,
  output logic              wvalid,
  input  logic              wready,
  input  logic [RESP_W-1:0] bresp,
  input  logic              bvalid,
  output logic              bready,
  output logic [ADDR_W-1:0] araddr,
  output logic              arvalid,
  input  logic              arready,
  input  logic [DATA_W-1:0] rdata,
  input  logic [RESP_W-1:0] rresp,
  input  logic              rvalid,
  output logic              rready
);

  arb_state_t state;

  logic [PORT_W-1:0]    rr_ptr;     // port that has priority at the next grant.
  logic [PORT_W-1:0]    grant;      // port served by the current transaction.
  logic [PORT_W-1:0]    pick;
  logic                 pick_valid;
  logic [NUM_PORTS-1:0] req_v;
  logic [NUM_PORTS-1:0] we_v;
  logic [NUM_PORTS-1:0] flushed_v;
  logic [ADDR_W-1:0]    addr_v  [NUM_PORTS];
  logic [DATA_W-1:0]    wdata_v [NUM_PORTS];
  logic [ADDR_W-1:0]    addr_q;
  logic [DATA_W-1:0]    wdata_q;
  logic                 aw_ok;      // AW already accepted in this write.
  logic                 w_ok;       // W already accepted in this write.
  logic                 xfer_done;
  logic                 xfer_err;
  logic                 flushed_q;

  // gather the channels into vectors and route the answer to the granted port.
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign req_v[p]     = cache[p].req;
    assign we_v[p]      = cache[p].we;
    assign flushed_v[p] = cache[p].flushed;
    assign addr_v[p]    = cache[p].addr;
    assign wdata_v[p]   = cache[p].wdata;

    assign cache[p].rdata = rdata;
    assign cache[p].done  = xfer_done && (grant == PORT_W'(p));
    assign cache[p].error = xfer_err && (grant == PORT_W'(p));
  end

  // first pending port counting up from the round-robin pointer.
  always_comb begin
    pick       = rr_ptr;
    pick_valid = 1'b0;
    for (int k = NUM_PORTS - 1; k >= 0; k--) begin // the smallest distance is written last.
      if (req_v[(int'(rr_ptr) + k) % NUM_PORTS]) begin
        pick       = PORT_W'((int'(rr_ptr) + k) % NUM_PORTS);
        pick_valid = 1'b1;
      end
    end
  end

  // the response beat completes the cache request in the same cycle.
  assign xfer_done = ((state == ARB_RDATA) && rvalid) || ((state == ARB_WRESP) && bvalid);
  assign xfer_err  = (state == ARB_RDATA) ? (rresp != RESP_OKAY) : (bresp != RESP_OKAY);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ARB_IDLE;
      rr_ptr <= '0; // port 0 goes first after reset.
      grant  <= '0;
      aw_ok  <= 1'b0;
      w_ok   <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (pick_valid) begin
            grant  <= pick;
            rr_ptr <= PORT_W'((int'(pick) + 1) % NUM_PORTS);
            aw_ok  <= 1'b0;
            w_ok   <= 1'b0;
            state  <= we_v[pick] ? ARB_WADDR : ARB_RADDR;
          end
        end
        ARB_RADDR: if (arready) state <= ARB_RDATA;
        ARB_RDATA: if (rvalid) state <= ARB_IDLE;
        ARB_WADDR: begin
          aw_ok <= aw_ok || awready; // the two channels may be accepted apart.
          w_ok  <= w_ok || wready;
          if ((aw_ok || awready) && (w_ok || wready)) state <= ARB_WRESP;
        end
        ARB_WRESP: if (bvalid) state <= ARB_IDLE;
        default:   state <= ARB_IDLE;
      endcase
    end
  end

  // address and data of the granted request, captured at the grant.
  always_ff @(posedge CLK) begin
    if ((state == ARB_IDLE) && pick_valid) begin
      addr_q  <= addr_v[pick];
      wdata_q <= wdata_v[pick];
    end
  end

  assign araddr  = addr_q;
  assign arvalid = (state == ARB_RADDR);
  assign rready  = (state == ARB_RDATA);
  assign awaddr  = addr_q;
  assign awvalid = (state == ARB_WADDR) && !aw_ok;
  assign wdata   = wdata_q;
  assign wstrb   = '1; // stores always write the full word.
  assign wvalid  = (state == ARB_WADDR) && !w_ok;
  assign bready  = (state == ARB_WRESP);

  // fence completes one cycle after every cache reports flushed.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) flushed_q <= 1'b0;
    else        flushed_q <= fence && (&flushed_v);
  end

  assign fence_done = fence && flushed_q; // drops with fence.

endmodule

// ==== split_cache_top.sv ====
/* top level of the split L1 subsystem: two caches in a generate loop,
   the bus arbiter and plain processor, fence and AXI4-Lite ports. */

`timescale 1ns/10ps

module split_cache_top
  import cache_pkg::*;
(
  input  logic              CLK,
  input  logic              rst_n,
  // port 0 serves instruction fetch.
  input  logic              ren_0,
  input  logic              wen_0,
  input  logic [ADDR_W-1:0] addr_0,
  input  logic [DATA_W-1:0] wdata_0,
  output logic [DATA_W-1:0] rdata_0,
  output logic              busy_0,
  output logic              error_0,
  // port 1 serves data.
  input  logic              ren_1,
  input  logic              wen_1,
  input  logic [ADDR_W-1:0] addr_1,
  input  logic [DATA_W-1:0] wdata_1,
  output logic [DATA_W-1:0] rdata_1,
  output logic              busy_1,
  output logic              error_1,
  input  logic              fence,
  output logic              fence_done,
  // AXI4-Lite master towards memory.
  output logic [ADDR_W-1:0] awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [DATA_W-1:0] wdata,
  output logic [STRB_W-1:0] wstrb,
  output logic              wvalid,
  input  logic              wready,
  input  logic [RESP_W-1:0] bresp,
  input  logic              bvalid,
  output logic              bready,
  output logic [ADDR_W-1:0] araddr,
  output logic              arvalid,
  input  logic              arready,
  input  logic [DATA_W-1:0] rdata,
  input  logic [RESP_W-1:0] rresp,
  input  logic              rvalid,
  output logic              rready
);

  // per-port wiring so the caches can sit in one loop.
  logic [NUM_PORTS-1:0] ren_v;
  logic [NUM_PORTS-1:0] wen_v;
  logic [NUM_PORTS-1:0] busy_v;
  logic [NUM_PORTS-1:0] error_v;
  logic [ADDR_W-1:0]    addr_v  [NUM_PORTS];
  logic [DATA_W-1:0]    wdata_v [NUM_PORTS];
  logic [DATA_W-1:0]    rdata_v [NUM_PORTS];

  assign ren_v      = {ren_1, ren_0};
  assign wen_v      = {wen_1, wen_0};
  assign addr_v[0]  = addr_0;
  assign addr_v[1]  = addr_1;
  assign wdata_v[0] = wdata_0;
  assign wdata_v[1] = wdata_1;
  assign rdata_0    = rdata_v[0];
  assign rdata_1    = rdata_v[1];
  assign busy_0     = busy_v[0];
  assign busy_1     = busy_v[1];
  assign error_0    = error_v[0];
  assign error_1    = error_v[1];

  mem_req_if cache_bus [NUM_PORTS] (.CLK(CLK)); // one request channel per cache.

  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_cache
    l1_cache l1_cache_inst (
      .CLK   (CLK),
      .rst_n (rst_n),
      .ren   (ren_v[g]),
      .wen   (wen_v[g]),
      .addr  (addr_v[g]),
      .wdata (wdata_v[g]),
      .rdata (rdata_v[g]),
      .busy  (busy_v[g]),
      .error (error_v[g]),
      .fence (fence),
      .mem   (cache_bus[g])
    );
  end

  bus_arbiter bus_arbiter_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .cache      (cache_bus),
    .fence      (fence),
    .fence_done (fence_done),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready)
  );

endmodule

// ==== split_cache_asserts.sv ====
/* concurrent checks on the AXI4-Lite valid signals, the idle outputs right
   after reset and the fence handshake, bound to the top level. */

`timescale 1ns/10ps

module split_cache_asserts (
  input logic CLK,
  input logic rst_n,
  input logic arvalid,
  input logic arready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bready,
  input logic rready,
  input logic busy_0,
  input logic busy_1,
  input logic error_0,
  input logic error_1,
  input logic fence,
  input logic fence_done
);

  // a valid that was not yet accepted stays up.
  ar_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
  aw_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
  w_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");

  // every port and bus output is idle in the first cycle out of reset.
  reset_idle: assert property (@(posedge CLK) $rose(rst_n) |->
    !busy_0 && !busy_1 && !error_0 && !error_1 && !fence_done &&
    !arvalid && !awvalid && !wvalid && !bready && !rready)
    else $error("an output was active in the first cycle after reset");

  // fence_done needs a held fence and a quiet bus behind the flushed caches.
  fence_only: assert property (@(posedge CLK) disable iff (!rst_n)
    fence_done |-> fence && !arvalid && !awvalid && !wvalid && !bready && !rready)
    else $error("fence_done raised without fence or with a bus transfer open");

endmodule

bind split_cache_top split_cache_asserts split_cache_asserts_inst (.*);

// ==== tb_split_cache.sv ====
/* testbench for the split L1 cache subsystem: clock, reset, an AXI4-Lite memory
   model with random stalls, a player for the pattern file and the checks. */

`timescale 1ns/10ps

module tb_split_cache;
  import cache_pkg::*;

  localparam int MAX_TESTS = 64;

  logic CLK, rst_n;
  logic ren_0, wen_0, ren_1, wen_1, fence, fence_done;
  logic [ADDR_W-1:0] addr_0, addr_1, awaddr, araddr;
  logic [DATA_W-1:0] wdata_0, wdata_1, rdata_0, rdata_1, wdata, rdata;
  logic busy_0, busy_1, error_0, error_1;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [STRB_W-1:0] wstrb;
  logic [RESP_W-1:0] bresp, rresp;

  // pattern table, one entry per operation line of the file.
  logic [8*24-1:0]   t_name [MAX_TESTS];
  int                t_port [MAX_TESTS];
  logic [7:0]        t_op   [MAX_TESTS];
  logic [ADDR_W-1:0] t_addr [MAX_TESTS];
  logic [DATA_W-1:0] t_data [MAX_TESTS];
  logic [DATA_W-1:0] t_exp  [MAX_TESTS];
  int                t_ars  [MAX_TESTS];
  int num_tests = 0;

  logic [DATA_W-1:0] mem_q [logic [ADDR_W-1:0]]; // words written so far; others read ~addr.
  integer seed = 12947;
  int ar_count = 0;   // AR handshakes seen by the memory model.
  int cycles = 0;
  int limit = 0;      // timeout in cycles, set once the patterns are known.
  int pass_cnt = 0;
  int fail_cnt = 0;

  split_cache_top split_cache_top_inst (.*);

  always #20 CLK = ~CLK;

  // run limit, 200 cycles per pattern line.
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    if (mem_q.exists(a)) return mem_q[a];
    return ~a; // untouched memory holds the inverse of its address.
  endfunction

  // byte lanes with a set strobe take the new data, the others keep the old word.
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] word;
    word = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    return word;
  endfunction

  function automatic int stall();
    return $unsigned($random(seed)) % 4; // 0 to 3 cycles.
  endfunction

  // read side of the memory model.
  int ar_dly, r_dly;
  logic r_pend;
  logic [ADDR_W-1:0] ra;
  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      r_pend  <= 1'b0;
      ar_dly  <= stall();
    end else begin
      if (arvalid && arready) begin
        arready  <= 1'b0;
        ra       <= araddr;
        r_pend   <= 1'b1;
        r_dly    <= stall();
        ar_dly   <= stall();
        ar_count <= ar_count + 1;
      end else if (arvalid && !r_pend && !rvalid) begin
        if (ar_dly == 0) arready <= 1'b1;
        else ar_dly <= ar_dly - 1;
      end
      if (r_pend && !rvalid) begin
        if (r_dly == 0) begin
          rvalid <= 1'b1;
          r_pend <= 1'b0;
          rdata  <= mem_word(ra);
          rresp  <= (ra >= 32'hF000_0000) ? 2'b10 : RESP_OKAY; // SLVERR above the limit.
        end else r_dly <= r_dly - 1;
      end
      if (rvalid && rready) rvalid <= 1'b0;
    end
  end

  // write side of the memory model. AW and W are taken apart, B follows both.
  int aw_dly, w_dly, b_dly;
  logic aw_got, w_got;
  logic [ADDR_W-1:0] wa;
  logic [DATA_W-1:0] wd;
  logic [STRB_W-1:0] ws;
  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      aw_dly  <= stall();
      w_dly   <= stall();
      b_dly   <= stall();
    end else begin
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        wa      <= awaddr;
        aw_dly  <= stall();
      end else if (awvalid && !aw_got) begin
        if (aw_dly == 0) awready <= 1'b1;
        else aw_dly <= aw_dly - 1;
      end
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_got  <= 1'b1;
        wd     <= wdata;
        ws     <= wstrb;
        w_dly  <= stall();
      end else if (wvalid && !w_got) begin
        if (w_dly == 0) wready <= 1'b1;
        else w_dly <= w_dly - 1;
      end
      if (aw_got && w_got && !bvalid) begin
        if (b_dly == 0) begin
          mem_q[wa] = merge_bytes(mem_word(wa), wd, ws);
          bvalid <= 1'b1;
          bresp  <= RESP_OKAY;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
        end else b_dly <= b_dly - 1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_dly  <= stall();
      end
    end
  end

  // waits until every port in mask has shown busy low, then drops its command.
  task automatic await_ports(input logic [1:0] mask, output logic [DATA_W-1:0] rd0,
                             output logic [DATA_W-1:0] rd1, output logic er0, output logic er1);
    logic [1:0] pend;
    pend = mask;
    while (pend != 2'b00) begin
      @(negedge CLK); // outputs are settled half a cycle after the edge.
      if (pend[0] && !busy_0) begin
        rd0 = rdata_0;
        er0 = error_0;
        pend[0] = 1'b0;
      end
      if (pend[1] && !busy_1) begin
        rd1 = rdata_1;
        er1 = error_1;
        pend[1] = 1'b0;
      end
      @(posedge CLK);
      if (!pend[0]) begin
        ren_0 <= 1'b0;
        wen_0 <= 1'b0;
      end
      if (!pend[1]) begin
        ren_1 <= 1'b0;
        wen_1 <= 1'b0;
      end
    end
  endtask

  task automatic compare(input logic [8*24-1:0] nm, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act, inout logic ok);
    assert (act === exp) else begin
      $display("mismatch %0s: expected %h, actual %h", nm, exp, act);
      ok = 1'b0;
    end
  endtask

  initial begin
    int fd, n;
    logic [8*128-1:0] line;
    logic [DATA_W-1:0] rd0, rd1;
    logic er0, er1, ok;
    int ar_start;
    {CLK, rst_n, fence, ren_0, wen_0, ren_1, wen_1} = '0;
    {addr_0, addr_1, wdata_0, wdata_1} = '0;
    {rdata, rresp, bresp} = '0;
    {arready, rvalid, awready, wready, bvalid} = '0;
    fd = $fopen("split_cache_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open split_cache_patterns.txt");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
        n = $sscanf(line, "%s %d %s %h %h %h %d", t_name[num_tests], t_port[num_tests],
                    t_op[num_tests], t_addr[num_tests], t_data[num_tests],
                    t_exp[num_tests], t_ars[num_tests]);
        if (n == 7) num_tests++; // comment and blank lines fall short.
      end
      $fclose(fd);
      limit = 200 * num_tests;
      repeat (4) @(posedge CLK);
      rst_n <= 1'b1;
      for (int i = 0; i < num_tests; i++) begin
        ok = 1'b1;
        ar_start = ar_count;
        {er0, er1} = 2'b00;
        @(posedge CLK);
        case (t_op[i])
          "F": begin
            fence <= 1'b1;
            do @(negedge CLK); while (!fence_done);
            @(posedge CLK);
            fence <= 1'b0;
            @(posedge CLK); // caches leave the flush state here.
          end
          "B": begin // port 0 reads addr, port 1 reads the data column as an address.
            ren_0  <= 1'b1;
            addr_0 <= t_addr[i];
            ren_1  <= 1'b1;
            addr_1 <= t_data[i];
            await_ports(2'b11, rd0, rd1, er0, er1);
            compare(t_name[i], t_exp[i], rd0, ok);
            compare(t_name[i], ~t_data[i], rd1, ok);
          end
          default: begin
            if (t_port[i] == 0) begin
              ren_0   <= (t_op[i] != "W");
              wen_0   <= (t_op[i] == "W");
              addr_0  <= t_addr[i];
              wdata_0 <= t_data[i];
            end else begin
              ren_1   <= (t_op[i] != "W");
              wen_1   <= (t_op[i] == "W");
              addr_1  <= t_addr[i];
              wdata_1 <= t_data[i];
            end
            await_ports(t_port[i] == 0 ? 2'b01 : 2'b10, rd0, rd1, er0, er1);
            if (t_port[i] != 0) begin
              rd0 = rd1;
              er0 = er1;
            end
            if (t_op[i] == "R") compare(t_name[i], t_exp[i], rd0, ok);
            if (t_op[i] == "W") compare(t_name[i], t_exp[i], mem_word(t_addr[i]), ok);
          end
        endcase
        assert ((er0 | er1) == (t_op[i] == "E")) else begin
          $display("mismatch %0s: expected error flag %b, actual %b", t_name[i],
                   t_op[i] == "E", er0 | er1);
          ok = 1'b0;
        end
        assert (ar_count - ar_start == t_ars[i]) else begin
          $display("mismatch %0s: expected %0d AR handshakes, actual %0d", t_name[i],
                   t_ars[i], ar_count - ar_start);
          ok = 1'b0;
        end
        if (ok) pass_cnt++;
        else fail_cnt++;
        $display("%0s: %0s", t_name[i], ok ? "ok" : "failed");
      end
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && num_tests > 0) $display("RESULT: PASS");
      else $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

// ==== split_cache_patterns.txt ====
# columns: name port op(R read, W write, F fence, B both ports read, E read with error)
#          address write_data expected ar_handshakes, numbers in hex except port and ar count
miss_p0_w0      0 R 00000000 00000000 ffffffff 4
hit_p0_w1       0 R 00000004 00000000 fffffffb 0
hit_p0_w2       0 R 00000008 00000000 fffffff7 0
hit_p0_w3       0 R 0000000c 00000000 fffffff3 0
hit_p0_w0       0 R 00000000 00000000 ffffffff 0
miss_p1_mid     1 R 00000048 00000000 ffffffb7 4
hit_p1_w0       1 R 00000040 00000000 ffffffbf 0
hit_p1_w3       1 R 0000004c 00000000 ffffffb3 0
hit_p1_w1       1 R 00000044 00000000 ffffffbb 0
wr_miss_p1      1 W 00000200 12345678 12345678 0
rd_after_wmiss  1 R 00000200 00000000 12345678 4
wr_hit_p1       1 W 00000204 a5a5a5a5 a5a5a5a5 0
rd_after_whit   1 R 00000204 00000000 a5a5a5a5 0
fill_p0_shared  0 R 00000100 00000000 fffffeff 4
wr_shared_p1    1 W 00000104 cafef00d cafef00d 0
stale_p0        0 R 00000104 00000000 fffffefb 0
fence_all       0 F 00000000 00000000 00000000 0
fresh_p0        0 R 00000104 00000000 cafef00d 4
refetch_p1      1 R 00000204 00000000 a5a5a5a5 4
dual_miss       0 B 00000300 00000344 fffffcff 8
dual_hit_p0     0 R 00000300 00000000 fffffcff 0
dual_hit_p1     1 R 00000344 00000000 fffffcbb 0
err_read_p1     1 E f0000010 00000000 00000000 1
err_repeat_p1   1 E f0000010 00000000 00000000 1
err_read_p0     0 E f0000400 00000000 00000000 1
ok_after_err    1 R 00000010 00000000 ffffffef 4
fence_again     1 F 00000000 00000000 00000000 0
refetch_p0      0 R 00000300 00000000 fffffcff 4

// ==== sources.f ====
cache_pkg.sv
mem_req_if.sv
l1_cache.sv
bus_arbiter.sv
split_cache_top.sv
split_cache_asserts.sv
tb_split_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the split cache testbench with Verilator.
# The run counts as failed if any step fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_split_cache \
  -f sources.f \
  -o sim_split_cache
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_split_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
